/* verilog.f */
+incdir+logic
+incdir+bench
logic/scalar_pkg.sv
logic/instr_mem.sv
logic/fetch_ctrl.sv
logic/issue_ctrl.sv
logic/reg_bank.sv
logic/exec_unit.sv
logic/scalar_unit.sv
bench/tb_scalar_unit.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_scalar_unit \
	-f verilog.f -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator returned an error status" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

/* bench/tb_program.svh */
// Test programs, expected trace storage and the reference model of the instruction set
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

scalar_pkg::instr_t		prog [$];		// Program of the current test
scalar_pkg::data_t		exp_data [$];	// scalar_data per vector command
scalar_pkg::instr_t		exp_cmd [$];
scalar_pkg::lane_t		exp_lane;
logic					exp_term;

function automatic scalar_pkg::instr_t encode(input scalar_pkg::opcode_e op,
		input int dst, input int src1, input int src2, input logic [15:0] imm);
	scalar_pkg::instr_t w;
	w.op	= op;
	w.dst	= scalar_pkg::reg_idx_t'(dst);
	w.src1	= scalar_pkg::reg_idx_t'(src1);
	w.src2	= scalar_pkg::reg_idx_t'(src2);
	w.imm	= imm;
	return w;
endfunction

function automatic logic [15:0] random_word();
	return 16'($urandom);
endfunction

// r0 is never written, so zeroed fields never see a pending register
function automatic void build_program(input int sel);
	prog.delete();
	case (sel)
		0: begin	// Odd and even sources and destinations, back-to-back hazards
			prog.push_back(encode(scalar_pkg::op_addi, 1, 0, 0, random_word()));
			prog.push_back(encode(scalar_pkg::op_addi, 2, 0, 0, random_word()));
			prog.push_back(encode(scalar_pkg::op_addi, 3, 0, 0, random_word()));
			prog.push_back(encode(scalar_pkg::op_add, 4, 1, 2, 16'd0));
			prog.push_back(encode(scalar_pkg::op_sub, 5, 4, 3, 16'd0));
			prog.push_back(encode(scalar_pkg::op_vcmd, 0, 5, 0, random_word()));
			prog.push_back(encode(scalar_pkg::op_and, 6, 5, 1, 16'd0));
			prog.push_back(encode(scalar_pkg::op_or, 7, 6, 2, 16'd0));
			prog.push_back(encode(scalar_pkg::op_xor, 8, 7, 3, 16'd0));
			prog.push_back(encode(scalar_pkg::op_vcmd, 0, 8, 0, random_word()));
			prog.push_back(encode(scalar_pkg::op_vcmd, 0, 4, 0, random_word()));
			prog.push_back(encode(scalar_pkg::op_halt, 0, 0, 0, 16'd0));
		end
		1: begin	// Count-down loop, then a jump over a command
			// At least three passes, so brz falls through after a backward jump
			prog.push_back(encode(scalar_pkg::op_addi, 1, 0, 0, 16'($urandom_range(5, 3))));
			prog.push_back(encode(scalar_pkg::op_addi, 2, 0, 0, random_word()));
			prog.push_back(encode(scalar_pkg::op_addi, 3, 0, 0, 16'hffff));
			prog.push_back(encode(scalar_pkg::op_vcmd, 0, 1, 0, random_word()));	// Loop head
			prog.push_back(encode(scalar_pkg::op_add, 2, 2, 1, 16'd0));
			prog.push_back(encode(scalar_pkg::op_vcmd, 0, 2, 0, random_word()));
			prog.push_back(encode(scalar_pkg::op_add, 1, 1, 3, 16'd0));
			prog.push_back(encode(scalar_pkg::op_brz, 0, 1, 0, 16'd9));
			prog.push_back(encode(scalar_pkg::op_jmp, 0, 0, 0, 16'd3));
			prog.push_back(encode(scalar_pkg::op_jmp, 0, 0, 0, 16'd11));
			prog.push_back(encode(scalar_pkg::op_vcmd, 0, 2, 0, 16'hdead));	// Skipped
			prog.push_back(encode(scalar_pkg::op_halt, 0, 0, 0, 16'd0));
		end
		default: begin
			prog.push_back(encode(scalar_pkg::op_addi, 5, 0, 0, random_word()));
			prog.push_back(encode(scalar_pkg::op_setlane, 0, 5, 0, 16'd0));
			prog.push_back(encode(scalar_pkg::op_vcmd, 0, 5, 0, random_word()));
			prog.push_back(encode(scalar_pkg::op_halt, 0, 0, 0, 16'd0));
		end
	endcase
endfunction

// Runs the program on 16 zeroed registers and records what the vector unit should see
function automatic void predict();
	scalar_pkg::data_t		regs [16];
	scalar_pkg::instr_t		w;
	int						pc;
	int						steps;
	exp_data.delete();
	exp_cmd.delete();
	exp_lane = '0;
	exp_term = 1'b0;
	foreach (regs[i]) regs[i] = '0;
	pc = 0;
	steps = 0;
	while (!exp_term && pc < prog.size() && steps < 1000) begin
		w = prog[pc];
		pc++;
		steps++;
		case (w.op)
			scalar_pkg::op_add:		regs[w.dst] = regs[w.src1] + regs[w.src2];
			scalar_pkg::op_sub:		regs[w.dst] = regs[w.src1] - regs[w.src2];
			scalar_pkg::op_and:		regs[w.dst] = regs[w.src1] & regs[w.src2];
			scalar_pkg::op_or:		regs[w.dst] = regs[w.src1] | regs[w.src2];
			scalar_pkg::op_xor:		regs[w.dst] = regs[w.src1] ^ regs[w.src2];
			scalar_pkg::op_addi:	regs[w.dst] = regs[w.src1] + w.imm;
			scalar_pkg::op_brz:		if (regs[w.src1] == '0) pc = int'(w.imm);
			scalar_pkg::op_jmp:		pc = int'(w.imm);
			scalar_pkg::op_setlane:	exp_lane = regs[w.src1][$bits(scalar_pkg::lane_t)-1:0];
			scalar_pkg::op_vcmd: begin
				exp_data.push_back(regs[w.src1]);
				exp_cmd.push_back(w);
			end
			scalar_pkg::op_halt:	exp_term = 1'b1;
			default: ;
		endcase
	end
endfunction

`endif

/* bench/tb_scalar_unit.sv */
// Testbench for the scalar unit: clock, reset, program load, output compare, timeout
`default_nettype none
`timescale 1ns/1ns

module tb_scalar_unit;

	logic					clock = 1'b0;
	logic					reset;
	logic					en;
	logic					req_st;
	scalar_pkg::instr_t		instr;
	logic					ack_st;
	scalar_pkg::instr_t		v_command;
	scalar_pkg::data_t		scalar_data;
	logic					v_valid;
	scalar_pkg::lane_t		lane_en;
	logic					term;

	string		test_name = "none";
	string		names [3] = '{"arith", "branch", "lane"};
	int			cycles = 0;
	int			limit = 200;		// Cycles allowed from reset, set per program

	`include "tb_program.svh"

	scalar_unit scalar_unit_i (
		.clock, .reset, .en, .req_st, .instr, .ack_st,
		.v_command, .scalar_data, .v_valid, .lane_en, .term
	);

	always #10 clock = ~clock;

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	////////////////////////////////////////
	// Timeout and output compare
	////////////////////////////////////////

	always @(posedge clock) begin
		if (reset) begin
			cycles = 0;
		end else begin
			cycles = cycles + 1;
			assert (cycles <= limit) else
				fail_run($sformatf("timeout: run hung in test %s after %0d cycles",
					test_name, cycles));
		end
	end

	always @(negedge clock) begin
		if (v_valid) begin
			assert (!term) else fail_run("vector command seen after termination");
			assert (exp_cmd.size() > 0) else
				fail_run($sformatf("unexpected extra vector command in test %s", test_name));
			assert (v_command == exp_cmd[0]) else
				fail_run($sformatf("error %s: v_command expected %h actual %h",
					test_name, exp_cmd[0], v_command));
			assert (scalar_data == exp_data[0]) else
				fail_run($sformatf("error %s: scalar_data expected %h actual %h",
					test_name, exp_data[0], scalar_data));
			void'(exp_cmd.pop_front());
			void'(exp_data.pop_front());
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	task automatic load_program();
		@(negedge clock);
		foreach (prog[i]) begin
			req_st	= 1'b1;
			instr	= prog[i];
			@(negedge clock);
			req_st	= 1'b0;
			assert (ack_st === 1'b1) else fail_run("ack_st missing one cycle after req_st");
			@(negedge clock);
			assert (ack_st === 1'b0) else fail_run("ack_st held longer than one cycle");
		end
	endtask

	initial begin
		reset	= 1'b1;
		en		= 1'b0;
		req_st	= 1'b0;
		instr	= '0;
		void'($urandom(32));
		foreach (names[t]) begin
			test_name = names[t];
			build_program(t);
			predict();
			limit = 64 * prog.size() + 200;
			@(negedge clock);
			reset = 1'b1;
			repeat (5) @(negedge clock);
			reset = 1'b0;
			load_program();
			en = 1'b1;						// Held for the whole run
			while (term != exp_term) @(negedge clock);
			repeat (8) @(negedge clock);	// Quiet window after halt
			assert (exp_cmd.size() == 0) else
				fail_run($sformatf("test %s ended with %0d vector commands missing",
					test_name, exp_cmd.size()));
			assert (lane_en == exp_lane) else
				fail_run($sformatf("error %s: lane_en expected %h actual %h",
					test_name, exp_lane, lane_en));
			$display("test %s done after %0d cycles", test_name, cycles);
			en = 1'b0;
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/scalar_unit.sv */
// Scalar unit top level: instruction store, fetch, issue, register banks, execute
`default_nettype none
`timescale 1ns/1ns

module scalar_unit (
	input  logic					clock,
	input  logic					reset,
	input  logic					en,				// Run enable level
	input  logic					req_st,			// Program store strobe
	input  scalar_pkg::instr_t		instr,
	output logic					ack_st,
	output scalar_pkg::instr_t		v_command,
	output scalar_pkg::data_t		scalar_data,
	output logic					v_valid,
	output scalar_pkg::lane_t		lane_en,
	output logic					term
);

	logic					ld_req;
	scalar_pkg::pc_t		ld_addr;
	scalar_pkg::instr_t		ld_word;
	scalar_pkg::instr_t		fetched;
	logic					fetched_valid;
	logic					stall;
	scalar_pkg::issue_t		issued;
	scalar_pkg::wb_t		wb;
	logic					redirect;
	scalar_pkg::pc_t		target;
	scalar_pkg::data_t		odd_data1;
	scalar_pkg::data_t		odd_data2;
	scalar_pkg::data_t		even_data1;
	scalar_pkg::data_t		even_data2;

	////////////////////////////////////////
	// Front end
	////////////////////////////////////////

	instr_mem u_imem (
		.clock(clock), .reset(reset),
		.req_st(req_st), .st_instr(instr), .ack_st(ack_st),
		.req_ld(ld_req), .ld_addr(ld_addr), .ld_instr(ld_word)
	);

	fetch_ctrl u_fetch (
		.clock(clock), .reset(reset), .en(en), .stall(stall),
		.redirect(redirect), .target(target), .word(ld_word),
		.req_ld(ld_req), .addr(ld_addr),
		.fetched(fetched), .fetched_valid(fetched_valid)
	);

	issue_ctrl u_issue (
		.clock(clock), .reset(reset),
		.fetched(fetched), .fetched_valid(fetched_valid),
		.wb(wb), .stall(stall), .issued(issued)
	);

	////////////////////////////////////////
	// Register read and execute
	////////////////////////////////////////

	reg_bank #(.BANK_ODD(1'b0)) u_bank_even (
		.clock(clock), .reset(reset),
		.rd_idx1(issued.instr.src1), .rd_idx2(issued.instr.src2),
		.rd_data1(even_data1), .rd_data2(even_data2), .wb(wb)
	);

	reg_bank #(.BANK_ODD(1'b1)) u_bank_odd (
		.clock(clock), .reset(reset),
		.rd_idx1(issued.instr.src1), .rd_idx2(issued.instr.src2),
		.rd_data1(odd_data1), .rd_data2(odd_data2), .wb(wb)
	);

	exec_unit u_exec (
		.clock(clock), .reset(reset), .issued(issued),
		.odd1(odd_data1), .odd2(odd_data2), .even1(even_data1), .even2(even_data2),
		.wb(wb), .redirect(redirect), .target(target),
		.v_command(v_command), .scalar_data(scalar_data), .v_valid(v_valid),
		.lane_en(lane_en), .term(term)
	);

endmodule

`default_nettype wire

/* logic/exec_unit.sv */
// Execute stage: operand select, ALU, branch resolve, write-back, lane mask, vector command
`default_nettype none
`timescale 1ns/1ns

`include "scalar_cfg.svh"

module exec_unit (
	input  logic					clock,
	input  logic					reset,
	input  scalar_pkg::issue_t		issued,
	input  scalar_pkg::data_t		odd1,
	input  scalar_pkg::data_t		odd2,
	input  scalar_pkg::data_t		even1,
	input  scalar_pkg::data_t		even2,
	output scalar_pkg::wb_t			wb,
	output logic					redirect,
	output scalar_pkg::pc_t			target,
	output scalar_pkg::instr_t		v_command,
	output scalar_pkg::data_t		scalar_data,
	output logic					v_valid,
	output scalar_pkg::lane_t		lane_en,
	output logic					term
);

	logic					rd_valid;
	scalar_pkg::instr_t		rd_instr;
	scalar_pkg::pc_t		rd_pc;
	scalar_pkg::pc_t		skew;			// Real minus issue-order address
	scalar_pkg::data_t		src1;
	scalar_pkg::data_t		src2;
	scalar_pkg::data_t		alu_out;
	logic					writes_reg;
	logic					is_ctrl;
	logic					taken;
	logic					wb_valid;
	scalar_pkg::reg_idx_t	wb_dst;
	scalar_pkg::data_t		wb_data;

	always_ff @(posedge clock) begin	// Register read stage
		if (reset) rd_valid <= 1'b0;
		else rd_valid <= issued.valid;
		rd_instr	<= issued.instr;
		rd_pc		<= issued.pc;
	end

	assign src1 = rd_instr.src1[0] ? odd1 : even1;
	assign src2 = rd_instr.src2[0] ? odd2 : even2;

	always_comb begin
		alu_out		= src1;
		writes_reg	= 1'b1;
		case (rd_instr.op)
			scalar_pkg::op_add:		alu_out = src1 + src2;
			scalar_pkg::op_sub:		alu_out = src1 - src2;
			scalar_pkg::op_and:		alu_out = src1 & src2;
			scalar_pkg::op_or:		alu_out = src1 | src2;
			scalar_pkg::op_xor:		alu_out = src1 ^ src2;
			scalar_pkg::op_addi:	alu_out = src1 + rd_instr.imm;
			default:				writes_reg = 1'b0;
		endcase
	end

	assign is_ctrl	= (rd_instr.op == scalar_pkg::op_brz) || (rd_instr.op == scalar_pkg::op_jmp);
	assign taken	= (rd_instr.op == scalar_pkg::op_jmp) ||
		((rd_instr.op == scalar_pkg::op_brz) && (src1 == '0));

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_valid <= 1'b0;
			redirect <= 1'b0;
			v_valid <= 1'b0;
			skew <= '0;
			lane_en <= '0;
			term <= 1'b0;
		end else begin
			wb_valid	<= rd_valid & writes_reg;
			redirect	<= rd_valid & is_ctrl;
			v_valid		<= rd_valid & (rd_instr.op == scalar_pkg::op_vcmd);
			if (rd_valid && taken) skew <= rd_instr.imm[`PC_W-1:0] - rd_pc - 1'b1;
			if (rd_valid && rd_instr.op == scalar_pkg::op_setlane) begin
				lane_en	<= src1[`NUM_LANES-1:0];
			end
			if (rd_valid && rd_instr.op == scalar_pkg::op_halt) term <= 1'b1;	// Sticky
		end
	end

	////////////////////////////////////////
	// Result payload
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		wb_dst		<= rd_instr.dst;
		wb_data		<= alu_out;
		target		<= taken ? rd_instr.imm[`PC_W-1:0] : rd_pc + skew + 1'b1;	// Fall-through
		v_command	<= rd_instr;
		scalar_data	<= src1;
	end

	assign wb = '{valid: wb_valid, dst: wb_dst, data: wb_data};

endmodule

`default_nettype wire

/* logic/reg_bank.sv */
// One register bank of eight words: two synchronous read ports, one write port
`default_nettype none
`timescale 1ns/1ns

`include "scalar_cfg.svh"

module reg_bank #(
	parameter bit BANK_ODD = 1'b0		// Parity of the indices held here
) (
	input  logic					clock,
	input  logic					reset,
	input  scalar_pkg::reg_idx_t	rd_idx1,
	input  scalar_pkg::reg_idx_t	rd_idx2,
	output scalar_pkg::data_t		rd_data1,
	output scalar_pkg::data_t		rd_data2,
	input  scalar_pkg::wb_t			wb
);

	localparam int DEPTH = 2 ** (`REG_IDX_W - 1);

	scalar_pkg::data_t	regs [DEPTH];
	logic				wr_en;

	// Lowest index bit selects the bank
	assign wr_en = wb.valid & (wb.dst[0] == BANK_ODD);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				regs[i]	<= '0;
			end
		end else if (wr_en) begin
			regs[wb.dst[`REG_IDX_W-1:1]]	<= wb.data;
		end
	end

	// Both ports read every cycle
	always_ff @(posedge clock) begin
		rd_data1	<= regs[rd_idx1[`REG_IDX_W-1:1]];
		rd_data2	<= regs[rd_idx2[`REG_IDX_W-1:1]];
	end

endmodule

`default_nettype wire

/* logic/issue_ctrl.sv */
// Issue control: register scoreboard, hazard stall and issue register
`default_nettype none
`timescale 1ns/1ns

`include "scalar_cfg.svh"

module issue_ctrl (
	input  logic					clock,
	input  logic					reset,
	input  scalar_pkg::instr_t		fetched,
	input  logic					fetched_valid,
	input  scalar_pkg::wb_t			wb,
	output logic					stall,
	output scalar_pkg::issue_t		issued
);

	localparam int NUM_REGS = 2 ** `REG_IDX_W;

	logic [NUM_REGS-1:0]	pending;		// One bit per register in flight
	logic [NUM_REGS-1:0]	set_mask;
	logic [NUM_REGS-1:0]	clr_mask;
	logic					hazard;
	logic					go;
	logic					writes_reg;
	scalar_pkg::pc_t		seq_pc;			// Sequential issue address
	logic					issue_valid;
	scalar_pkg::instr_t		issue_instr;
	scalar_pkg::pc_t		issue_pc;

	assign hazard	= pending[fetched.src1] | pending[fetched.src2] | pending[fetched.dst];
	assign stall	= fetched_valid & hazard;
	assign go		= fetched_valid & ~hazard;

	always_comb begin
		case (fetched.op)
			scalar_pkg::op_add, scalar_pkg::op_sub, scalar_pkg::op_and,
			scalar_pkg::op_or, scalar_pkg::op_xor, scalar_pkg::op_addi: writes_reg = 1'b1;
			default: writes_reg = 1'b0;
		endcase
	end

	always_comb begin
		set_mask	= '0;
		clr_mask	= '0;
		if (go && writes_reg) begin
			set_mask[fetched.dst]	= 1'b1;
		end
		if (wb.valid) begin
			clr_mask[wb.dst]	= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pending		<= '0;
			seq_pc		<= '0;
			issue_valid	<= 1'b0;
		end else begin
			pending		<= (pending & ~clr_mask) | set_mask;
			issue_valid	<= go;			// Single-cycle issue
			if (go) begin
				seq_pc	<= seq_pc + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (go) begin
			issue_instr	<= fetched;
			issue_pc	<= seq_pc;
		end
	end

	assign issued = '{valid: issue_valid, instr: issue_instr, pc: issue_pc};

	a_wb_clears_pending: assert property (@(posedge clock) disable iff (reset)
		wb.valid |-> pending[wb.dst]);

endmodule

`default_nettype wire

/* logic/fetch_ctrl.sv */
// Fetch control: program counter, fetch request, branch wait and halt stop
`default_nettype none
`timescale 1ns/1ns

module fetch_ctrl (
	input  logic					clock,
	input  logic					reset,
	input  logic					en,
	input  logic					stall,			// Issue is holding the word
	input  logic					redirect,
	input  scalar_pkg::pc_t			target,
	input  scalar_pkg::instr_t		word,			// Returned by instr_mem
	output logic					req_ld,
	output scalar_pkg::pc_t			addr,
	output scalar_pkg::instr_t		fetched,
	output logic					fetched_valid
);

	scalar_pkg::pc_t	pc;
	logic				req_q;			// Word on the memory output is live
	logic				wait_br;
	logic				halted;
	logic				is_branch;
	logic				is_halt;
	logic				cf_now;
	logic				consumed;

	////////////////////////////////////////
	// Decode of the returned word
	////////////////////////////////////////

	assign is_branch	= (word.op == scalar_pkg::op_brz) || (word.op == scalar_pkg::op_jmp);
	assign is_halt		= (word.op == scalar_pkg::op_halt);
	assign cf_now		= req_q & (is_branch | is_halt);	// No fetch behind it
	assign consumed		= req_q & ~stall;

	// Redirect target goes straight to the memory
	assign addr		= redirect ? target : pc;
	assign req_ld	= en & ~stall & ~halted & ~cf_now & (~wait_br | redirect);

	assign fetched			= word;
	assign fetched_valid	= req_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc		<= '0;
			req_q	<= 1'b0;
			wait_br	<= 1'b0;
			halted	<= 1'b0;
		end else begin
			req_q	<= req_ld | (req_q & stall);
			if (req_ld) begin
				pc	<= addr + 1'b1;
			end else if (redirect) begin
				pc	<= target;
			end
			if (redirect) begin
				wait_br	<= 1'b0;
			end else if (consumed && is_branch) begin
				wait_br	<= 1'b1;
			end
			if (consumed && is_halt) begin
				halted	<= 1'b1;				// Stops for good
			end
		end
	end

	// Execute only resolves branches this unit is waiting on
	a_redirect_when_waiting: assert property (@(posedge clock) disable iff (reset)
		redirect |-> wait_br);

endmodule

`default_nettype wire

/* logic/instr_mem.sv */
// Instruction store with self-incrementing write address, store ack and synchronous read
`default_nettype none
`timescale 1ns/1ns

`include "scalar_cfg.svh"

module instr_mem (
	input  logic					clock,
	input  logic					reset,
	input  logic					req_st,
	input  scalar_pkg::instr_t		st_instr,
	output logic					ack_st,
	input  logic					req_ld,
	input  scalar_pkg::pc_t			ld_addr,
	output scalar_pkg::instr_t		ld_instr
);

	scalar_pkg::instr_t		mem [2**`PC_W];
	scalar_pkg::pc_t		wr_addr;		// Next store slot

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_addr	<= '0;
			ack_st	<= 1'b0;
		end else begin
			ack_st	<= req_st;				// One cycle after the strobe
			if (req_st) begin
				wr_addr	<= wr_addr + 1'b1;
			end
		end
	end

	// Storage and read port
	always_ff @(posedge clock) begin
		if (req_st) begin
			mem[wr_addr]	<= st_instr;
		end
		if (req_ld) begin
			ld_instr	<= mem[ld_addr];	// Held while no request
		end
	end

	// Loading and running never overlap
	a_no_store_while_fetch: assert property (@(posedge clock) disable iff (reset)
		!(req_st && req_ld));

endmodule

`default_nettype wire

/* logic/scalar_pkg.sv */
// Scalar unit package: opcode enum, word typedefs, instruction and pipeline structs
`default_nettype none

`include "scalar_cfg.svh"

package scalar_pkg;

	////////////////////////////////////////
	// Plain word types
	////////////////////////////////////////

	typedef logic [`DATA_W-1:0]		data_t;
	typedef logic [`REG_IDX_W-1:0]	reg_idx_t;
	typedef logic [`PC_W-1:0]		pc_t;
	typedef logic [`NUM_LANES-1:0]	lane_t;

	typedef enum logic [3:0] {
		op_add		= 4'd0,
		op_sub		= 4'd1,
		op_and		= 4'd2,
		op_or		= 4'd3,
		op_xor		= 4'd4,
		op_addi		= 4'd5,
		op_brz		= 4'd6,		// Taken when src1 is zero
		op_jmp		= 4'd7,
		op_setlane	= 4'd8,		// Low bits of src1 into lane mask
		op_vcmd		= 4'd9,		// Forwarded to the vector unit
		op_halt		= 4'd10
	} opcode_e;

	////////////////////////////////////////
	// Pipeline structs
	////////////////////////////////////////

	// 32-bit instruction word
	typedef struct packed {
		opcode_e				op;
		reg_idx_t				dst;
		reg_idx_t				src1;
		reg_idx_t				src2;
		logic [`IMM_W-1:0]		imm;
	} instr_t;

	typedef struct packed {
		logic		valid;
		instr_t		instr;
		pc_t		pc;		// Issue-order address
	} issue_t;

	typedef struct packed {
		logic		valid;
		reg_idx_t	dst;
		data_t		data;
	} wb_t;

endpackage

`default_nettype wire

/* logic/scalar_cfg.svh */
// Width and depth macros for the scalar issue unit
`ifndef SCALAR_CFG_SVH
`define SCALAR_CFG_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

`define DATA_W		16	// Scalar data word
`define IMM_W		16	// Immediate field

////////////////////////////////////////
// Register file, program and lanes
////////////////////////////////////////

// Lowest index bit picks odd or even bank
`define REG_IDX_W	4	// 16 registers
`define PC_W		6	// 64-word program
`define NUM_LANES	8	// Lane-enable mask width

`endif
